//--- axi_mem/axi_mem_array.sv
`timescale 1ns/1ps

module axi_mem_array (
  input  logic                              clk,

  input  logic                              i_wr_en,
  input  mem_pkg::mem_addr_t                i_wr_addr,
  input  logic [axi_pkg::DATA_WIDTH-1:0]    i_wr_data,
  input  logic [axi_pkg::STRB_WIDTH-1:0]    i_wr_strb,

  input  logic                              i_rd_en,
  input  mem_pkg::mem_addr_t                i_rd_addr,
  output logic [axi_pkg::DATA_WIDTH-1:0]    o_rd_data
);

  logic [axi_pkg::DATA_WIDTH-1:0] mem [mem_pkg::MEM_DEPTH];

  // One byte lane per strobe bit
  always_ff @(posedge clk) begin
    for (int i = 0; i < axi_pkg::STRB_WIDTH; i++) begin
      if (i_wr_en && i_wr_strb[i]) begin
        mem[i_wr_addr][i*8 +: 8] <= i_wr_data[i*8 +: 8];
      end
    end
  end

  // Holds its value while no new read is issued
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

//--- axi_mem/axi_mem_reader.sv
`timescale 1ns/1ps

module axi_mem_reader (
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic                              i_ar_valid,
  input  axi_pkg::axi_addr_t                i_ar,
  output logic                              o_ar_ready,

  output logic                              o_r_valid,
  output axi_pkg::axi_r_t                   o_r,
  input  logic                              i_r_ready,

  output logic                              o_rd_en,
  output mem_pkg::mem_addr_t                o_rd_addr,
  input  logic [axi_pkg::DATA_WIDTH-1:0]    i_rd_data
);

  typedef enum logic {
    ST_IDLE,
    ST_BURST
  } state_t;

  state_t                         state;

  logic [axi_pkg::ID_WIDTH-1:0]   r_id;
  logic [axi_pkg::ADDR_WIDTH-1:0] r_addr;
  logic [7:0]                     r_len;
  logic [2:0]                     r_size;
  logic [1:0]                     r_burst;

  // R beat sidebands, aligned with the registered array data
  logic [axi_pkg::ID_WIDTH-1:0]   rid_q;
  logic                           rlast_q;

  logic [axi_pkg::ID_WIDTH-1:0]   cur_id;
  logic [axi_pkg::ADDR_WIDTH-1:0] cur_addr;
  logic [7:0]                     cur_len;
  logic [2:0]                     cur_size;
  logic [1:0]                     cur_burst;
  logic                           cur_last;
  logic                           ar_fire;
  logic                           slot_free;
  logic                           issue;

  assign ar_fire   = i_ar_valid && o_ar_ready;
  // R register empty or being consumed this cycle
  assign slot_free = !o_r_valid || i_r_ready;

  assign cur_id    = (state == ST_IDLE) ? i_ar.id    : r_id;
  assign cur_addr  = (state == ST_IDLE) ? i_ar.addr  : r_addr;
  assign cur_len   = (state == ST_IDLE) ? i_ar.len   : r_len;
  assign cur_size  = (state == ST_IDLE) ? i_ar.size  : r_size;
  assign cur_burst = (state == ST_IDLE) ? i_ar.burst : r_burst;
  assign cur_last  = (cur_len == 8'd0);

  assign issue = ((state == ST_BURST) || ar_fire) && slot_free;

  assign o_rd_en   = issue;
  assign o_rd_addr = cur_addr[axi_pkg::ADDR_WIDTH-1:mem_pkg::WORD_LSB];

  assign o_r = '{id: rid_q, data: i_rd_data, resp: axi_pkg::RESP_OKAY, last: rlast_q};

  // ------------------------------
  // State machine
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      o_ar_ready <= 1'b1;
      o_r_valid  <= 1'b0;
    end else begin
      if (issue) begin
        o_r_valid <= 1'b1;
      end else if (i_r_ready) begin
        o_r_valid <= 1'b0;
      end

      if (issue && cur_last) begin
        state      <= ST_IDLE;
        o_ar_ready <= 1'b1;
      end else if (ar_fire) begin
        state      <= ST_BURST;
        o_ar_ready <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      r_id    <= i_ar.id;
      r_size  <= i_ar.size;
      r_burst <= i_ar.burst;
    end
    if (ar_fire || issue) begin
      r_addr <= issue ? axi_pkg::next_addr(cur_addr, cur_size, cur_burst) : cur_addr;
      r_len  <= issue ? cur_len - 8'd1 : cur_len;
    end
    if (issue) begin
      rid_q   <= cur_id;
      rlast_q <= cur_last;
    end
  end

endmodule

//--- axi_mem/axi_mem_writer.sv
`timescale 1ns/1ps

module axi_mem_writer (
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic                              i_aw_valid,
  input  axi_pkg::axi_addr_t                i_aw,
  output logic                              o_aw_ready,

  input  logic                              i_w_valid,
  input  axi_pkg::axi_w_t                   i_w,
  output logic                              o_w_ready,

  output logic                              o_b_valid,
  output axi_pkg::axi_b_t                   o_b,
  input  logic                              i_b_ready,

  output logic                              o_wr_en,
  output mem_pkg::mem_addr_t                o_wr_addr,
  output logic [axi_pkg::DATA_WIDTH-1:0]    o_wr_data,
  output logic [axi_pkg::STRB_WIDTH-1:0]    o_wr_strb
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BURST,
    ST_RESP
  } state_t;

  state_t                        state;

  // Burst context latched from AW
  logic [axi_pkg::ID_WIDTH-1:0]   w_id;
  logic [axi_pkg::ADDR_WIDTH-1:0] w_addr;
  logic [2:0]                     w_size;
  logic [1:0]                     w_burst;

  logic [axi_pkg::ADDR_WIDTH-1:0] cur_addr;
  logic [2:0]                     cur_size;
  logic [1:0]                     cur_burst;
  logic                           aw_fire;
  logic                           w_fire;

  // ------------------------------
  // Handshakes
  // ------------------------------
  assign o_aw_ready = (state == ST_IDLE);
  // W held off while a response waits, first beat rides with AW
  assign o_w_ready  = (state == ST_BURST) || ((state == ST_IDLE) && i_aw_valid);
  assign aw_fire    = i_aw_valid && o_aw_ready;
  assign w_fire     = i_w_valid && o_w_ready;

  // In idle the beat uses the AW fields directly
  assign cur_addr  = (state == ST_IDLE) ? i_aw.addr  : w_addr;
  assign cur_size  = (state == ST_IDLE) ? i_aw.size  : w_size;
  assign cur_burst = (state == ST_IDLE) ? i_aw.burst : w_burst;

  // Array write port
  assign o_wr_en   = w_fire;
  assign o_wr_addr = cur_addr[axi_pkg::ADDR_WIDTH-1:mem_pkg::WORD_LSB];
  assign o_wr_data = i_w.data;
  assign o_wr_strb = i_w.strb;

  assign o_b = '{id: w_id, resp: axi_pkg::RESP_OKAY};

  // ------------------------------
  // State machine
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      o_b_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (aw_fire) begin
            state     <= (w_fire && i_w.last) ? ST_RESP : ST_BURST;
            o_b_valid <= w_fire && i_w.last;
          end
        end
        ST_BURST: begin
          if (w_fire && i_w.last) begin
            state     <= ST_RESP;
            o_b_valid <= 1'b1;
          end
        end
        ST_RESP: begin
          if (i_b_ready) begin
            state     <= ST_IDLE;
            o_b_valid <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      w_id    <= i_aw.id;
      w_size  <= i_aw.size;
      w_burst <= i_aw.burst;
    end
    if (aw_fire || w_fire) begin
      w_addr <= w_fire ? axi_pkg::next_addr(cur_addr, cur_size, cur_burst) : cur_addr;
    end
  end

endmodule

//--- axi_mem_top.f
common/axi_pkg.sv
common/mem_pkg.sv
design/skid_buffer.sv
axi_mem/axi_mem_array.sv
axi_mem/axi_mem_writer.sv
axi_mem/axi_mem_reader.sv
design/axi_mem_top.sv
bench/axi_mem_tb.sv

//--- bench/axi_mem_tb.sv
`timescale 1ns/1ps

module axi_mem_tb;

  localparam logic [1:0] INCR  = axi_pkg::BURST_INCR;
  localparam logic [1:0] FIXED = axi_pkg::BURST_FIXED;

  // One row of the stimulus table
  typedef struct packed {
    logic                           is_read;
    logic [axi_pkg::ID_WIDTH-1:0]   id;
    logic [axi_pkg::ADDR_WIDTH-1:0] addr;
    logic [7:0]                     len;
    logic [2:0]                     size;
    logic [1:0]                     burst;
    logic [axi_pkg::DATA_WIDTH-1:0] seed;
    logic [axi_pkg::STRB_WIDTH-1:0] strb;
    logic                           bp;
  } test_t;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               i_aw_valid;
  axi_pkg::axi_addr_t i_aw;
  logic               o_aw_ready;
  logic               i_w_valid;
  axi_pkg::axi_w_t    i_w;
  logic               o_w_ready;
  logic               o_b_valid;
  axi_pkg::axi_b_t    o_b;
  logic               i_b_ready;
  logic               i_ar_valid;
  axi_pkg::axi_addr_t i_ar;
  logic               o_ar_ready;
  logic               o_r_valid;
  axi_pkg::axi_r_t    o_r;
  logic               i_r_ready;

  test_t tests[$];
  string names[$];
  logic [axi_pkg::DATA_WIDTH-1:0] ref_mem [mem_pkg::MEM_DEPTH];

  // Writes whose B has not been taken yet
  logic [axi_pkg::ID_WIDTH-1:0] b_ids[$];
  string                        b_names[$];
  logic                         b_bp[$];

  int errors = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  axi_mem_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_aw_valid (i_aw_valid),
    .i_aw       (i_aw),
    .o_aw_ready (o_aw_ready),
    .i_w_valid  (i_w_valid),
    .i_w        (i_w),
    .o_w_ready  (o_w_ready),
    .o_b_valid  (o_b_valid),
    .o_b        (o_b),
    .i_b_ready  (i_b_ready),
    .i_ar_valid (i_ar_valid),
    .i_ar       (i_ar),
    .o_ar_ready (o_ar_ready),
    .o_r_valid  (o_r_valid),
    .o_r        (o_r),
    .i_r_ready  (i_r_ready)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  // ------------------------------
  // Table and reference model
  // ------------------------------
  function automatic void add_test(input string name, input logic is_read,
      input logic [3:0] id, input logic [7:0] addr, input logic [7:0] len,
      input logic [2:0] size, input logic [1:0] burst, input logic [15:0] seed,
      input logic [1:0] strb, input logic bp);
    test_t t;
    t = '{is_read: is_read, id: id, addr: addr, len: len, size: size, burst: burst,
          seed: seed, strb: strb, bp: bp};
    tests.push_back(t);
    names.push_back(name);
  endfunction

  function automatic void build_table;
    //       name          rd    id     addr   len   size  burst  seed      strb   bp
    add_test("single_wr",  1'b0, 4'd1,  8'h10, 8'd0, 3'd1, INCR,  16'ha5c3, 2'b11, 1'b0);
    add_test("single_rd",  1'b1, 4'd2,  8'h10, 8'd0, 3'd1, INCR,  16'h0000, 2'b11, 1'b0);
    add_test("incr_wr8",   1'b0, 4'd3,  8'h20, 8'd7, 3'd1, INCR,  16'h1000, 2'b11, 1'b0);
    add_test("incr_rd8",   1'b1, 4'd4,  8'h20, 8'd7, 3'd1, INCR,  16'h0000, 2'b11, 1'b0);
    add_test("fixed_wr4",  1'b0, 4'd5,  8'h40, 8'd3, 3'd1, FIXED, 16'h2200, 2'b11, 1'b0);
    add_test("fixed_rd3",  1'b1, 4'd6,  8'h40, 8'd2, 3'd1, FIXED, 16'h0000, 2'b11, 1'b0);
    add_test("strb_lo_wr", 1'b0, 4'd7,  8'h20, 8'd1, 3'd1, INCR,  16'h7e5a, 2'b01, 1'b0);
    add_test("strb_hi_wr", 1'b0, 4'd8,  8'h24, 8'd1, 3'd1, INCR,  16'h00e7, 2'b10, 1'b0);
    add_test("strb_rd",    1'b1, 4'd9,  8'h20, 8'd5, 3'd1, INCR,  16'h0000, 2'b11, 1'b0);
    add_test("bp_wr_a",    1'b0, 4'd10, 8'h80, 8'd5, 3'd1, INCR,  16'h3300, 2'b11, 1'b1);
    add_test("bp_wr_b",    1'b0, 4'd11, 8'h8c, 8'd3, 3'd1, INCR,  16'h4400, 2'b11, 1'b1);
    add_test("bp_wr_c",    1'b0, 4'd12, 8'h80, 8'd0, 3'd1, INCR,  16'h5500, 2'b10, 1'b1);
    add_test("bp_rd",      1'b1, 4'd13, 8'h80, 8'd9, 3'd1, INCR,  16'h0000, 2'b11, 1'b1);
  endfunction

  function automatic void update_ref(input logic [7:0] addr, input logic [15:0] data,
                                     input logic [1:0] strb);
    for (int i = 0; i < axi_pkg::STRB_WIDTH; i++) begin
      if (strb[i]) begin
        ref_mem[addr[axi_pkg::ADDR_WIDTH-1:mem_pkg::WORD_LSB]][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endfunction

  task automatic compare_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s expected 0x%0h actual 0x%0h", test, field, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("%s: %s", name, (test_errors == 0) ? "passed" : "failed");
  endtask

  // ------------------------------
  // Write side
  // ------------------------------
  task automatic issue_aw(input axi_pkg::axi_addr_t aw);
    logic done;
    done = 1'b0;
    i_aw = aw;
    i_aw_valid = 1'b1;
    while (!done) begin
      @(negedge clk);
      done = o_aw_ready;
      @(posedge clk);
      #1;
    end
    i_aw_valid = 1'b0;
  endtask

  task automatic stream_w(input int k);
    test_t      t;
    logic [7:0] addr;
    logic       done;
    t = tests[k];
    addr = t.addr;
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      i_w.data = t.seed + 16'(beat) * 16'h0111;
      i_w.strb = t.strb;
      i_w.last = (beat == int'(t.len));
      i_w_valid = 1'b1;
      update_ref(addr, i_w.data, t.strb);
      done = 1'b0;
      while (!done) begin
        @(negedge clk);
        done = o_w_ready;
        @(posedge clk);
        #1;
      end
      if (t.burst == INCR) begin
        addr = addr + (8'd1 << t.size);
      end
    end
    i_w_valid = 1'b0;
  endtask

  task automatic drain_b;
    while (b_ids.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Takes B responses in order with random bready stalls on back-pressure rows
  task automatic collect_b;
    int delay;
    forever begin
      @(posedge clk);
      #1;
      if (b_ids.size() != 0) begin
        delay = b_bp[0] ? int'($urandom_range(3, 0)) : 0;
        while (!o_b_valid) begin
          @(posedge clk);
          #1;
        end
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        i_b_ready = 1'b1;
        compare_value(b_names[0], "bid", 32'(b_ids[0]), 32'(o_b.id));
        compare_value(b_names[0], "bresp", 32'(axi_pkg::RESP_OKAY), 32'(o_b.resp));
        @(posedge clk);
        #1;
        i_b_ready = 1'b0;
        void'(b_ids.pop_front());
        void'(b_names.pop_front());
        void'(b_bp.pop_front());
      end
    end
  endtask

  task automatic write_burst(input int k);
    test_t              t;
    axi_pkg::axi_addr_t aw;
    t = tests[k];
    aw = '{id: t.id, addr: t.addr, len: t.len, size: t.size, burst: t.burst};
    b_ids.push_back(t.id);
    b_names.push_back(names[k]);
    b_bp.push_back(t.bp);
    fork
      issue_aw(aw);
      stream_w(k);
    join
    // Back-pressure rows go on while their B is still pending
    if (!t.bp) begin
      drain_b();
    end
  endtask

  // ------------------------------
  // Read side
  // ------------------------------
  task automatic read_burst(input int k);
    test_t              t;
    logic [7:0]         addr;
    mem_pkg::mem_addr_t word;
    logic               seen;
    int                 delay;
    t = tests[k];
    addr = t.addr;
    // Earlier writes must reach the array first
    drain_b();
    i_ar = '{id: t.id, addr: t.addr, len: t.len, size: t.size, burst: t.burst};
    i_ar_valid = 1'b1;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = o_ar_ready;
      @(posedge clk);
      #1;
    end
    i_ar_valid = 1'b0;
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      delay = t.bp ? int'($urandom_range(3, 0)) : 0;
      seen = 1'b0;
      while (!seen) begin
        @(negedge clk);
        seen = o_r_valid;
        @(posedge clk);
        #1;
      end
      repeat (delay) begin
        @(posedge clk);
        #1;
      end
      i_r_ready = 1'b1;
      @(negedge clk);
      word = addr[axi_pkg::ADDR_WIDTH-1:mem_pkg::WORD_LSB];
      compare_value(names[k], "rdata", 32'(ref_mem[word]), 32'(o_r.data));
      compare_value(names[k], "rid", 32'(t.id), 32'(o_r.id));
      compare_value(names[k], "rresp", 32'(axi_pkg::RESP_OKAY), 32'(o_r.resp));
      compare_value(names[k], "rlast", 32'(beat == int'(t.len)), 32'(o_r.last));
      @(posedge clk);
      #1;
      i_r_ready = 1'b0;
      if (t.burst == INCR) begin
        addr = addr + (8'd1 << t.size);
      end
    end
    @(negedge clk);
    if (o_r_valid) begin
      $display("Error: %s returned an R beat after its last beat", names[k]);
      errors++;
      test_errors++;
    end
    @(posedge clk);
    #1;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin : main
    int beats;
    beats = 0;
    void'($urandom(32'h7d1852a3));
    rst_n = 1'b0;
    i_aw_valid = 1'b0;
    i_aw = '0;
    i_w_valid = 1'b0;
    i_w = '0;
    i_b_ready = 1'b0;
    i_ar_valid = 1'b0;
    i_ar = '0;
    i_r_ready = 1'b0;
    build_table();
    foreach (tests[k]) begin
      beats += int'(tests[k].len) + 1;
    end
    cycle_limit = 20 * beats + 50;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fork
      collect_b();
    join_none

    // Idle state straight out of reset
    @(negedge clk);
    test_errors = 0;
    compare_value("reset_state", "ar_ready", 32'd1, 32'(o_ar_ready));
    compare_value("reset_state", "aw_ready", 32'd1, 32'(o_aw_ready));
    compare_value("reset_state", "w_ready", 32'd1, 32'(o_w_ready));
    compare_value("reset_state", "b_valid", 32'd0, 32'(o_b_valid));
    compare_value("reset_state", "r_valid", 32'd0, 32'(o_r_valid));
    report_test("reset_state");
    @(posedge clk);
    #1;

    foreach (tests[k]) begin
      test_errors = 0;
      if (tests[k].is_read) begin
        read_burst(k);
      end else begin
        write_burst(k);
      end
      report_test(names[k]);
    end
    drain_b();

    $display("Tests run: %0d, failed: %0d, mismatches: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- common/axi_pkg.sv
package axi_pkg;

  // ------------------------------
  // Bus geometry
  // ------------------------------
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 16;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int ID_WIDTH   = 4;

  // Burst and response codes
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] RESP_OKAY   = 2'b00;

  // ------------------------------
  // Channel payloads
  // ------------------------------

  // Shared by AW and AR, len unused on writes
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_addr_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

  // Byte address of the next beat, WRAP falls through to INCR
  function automatic logic [ADDR_WIDTH-1:0] next_addr(
      input logic [ADDR_WIDTH-1:0] addr,
      input logic [2:0]            size,
      input logic [1:0]            burst);
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return addr + (ADDR_WIDTH'(1) << size);
  endfunction

endpackage

//--- common/mem_pkg.sv
package mem_pkg;

  // Byte offset bits inside one data word
  localparam int WORD_LSB = $clog2(axi_pkg::STRB_WIDTH);

  // Word addressed storage covering the whole byte space
  localparam int MEM_ADDR_WIDTH = axi_pkg::ADDR_WIDTH - WORD_LSB;
  localparam int MEM_DEPTH      = 1 << MEM_ADDR_WIDTH;

  typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

endpackage

//--- design/axi_mem_top.sv
`timescale 1ns/1ps

module axi_mem_top (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               i_aw_valid,
  input  axi_pkg::axi_addr_t i_aw,
  output logic               o_aw_ready,

  input  logic               i_w_valid,
  input  axi_pkg::axi_w_t    i_w,
  output logic               o_w_ready,

  output logic               o_b_valid,
  output axi_pkg::axi_b_t    o_b,
  input  logic               i_b_ready,

  input  logic               i_ar_valid,
  input  axi_pkg::axi_addr_t i_ar,
  output logic               o_ar_ready,

  output logic               o_r_valid,
  output axi_pkg::axi_r_t    o_r,
  input  logic               i_r_ready
);

  // Buffered write side
  logic                           aw_valid;
  axi_pkg::axi_addr_t             aw;
  logic                           aw_ready;
  logic                           w_valid;
  axi_pkg::axi_w_t                w;
  logic                           w_ready;

  // Array ports
  logic                           wr_en;
  mem_pkg::mem_addr_t             wr_addr;
  logic [axi_pkg::DATA_WIDTH-1:0] wr_data;
  logic [axi_pkg::STRB_WIDTH-1:0] wr_strb;
  logic                           rd_en;
  mem_pkg::mem_addr_t             rd_addr;
  logic [axi_pkg::DATA_WIDTH-1:0] rd_data;

  // ------------------------------
  // Write path
  // ------------------------------
  skid_buffer #(.payload_t(axi_pkg::axi_addr_t)) u_aw_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_aw_valid),
    .i_data  (i_aw),
    .o_ready (o_aw_ready),
    .o_valid (aw_valid),
    .o_data  (aw),
    .i_ready (aw_ready)
  );

  skid_buffer #(.payload_t(axi_pkg::axi_w_t)) u_w_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_w_valid),
    .i_data  (i_w),
    .o_ready (o_w_ready),
    .o_valid (w_valid),
    .o_data  (w),
    .i_ready (w_ready)
  );

  axi_mem_writer u_writer (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_aw_valid (aw_valid),
    .i_aw       (aw),
    .o_aw_ready (aw_ready),
    .i_w_valid  (w_valid),
    .i_w        (w),
    .o_w_ready  (w_ready),
    .o_b_valid  (o_b_valid),
    .o_b        (o_b),
    .i_b_ready  (i_b_ready),
    .o_wr_en    (wr_en),
    .o_wr_addr  (wr_addr),
    .o_wr_data  (wr_data),
    .o_wr_strb  (wr_strb)
  );

  // ------------------------------
  // Read path and storage
  // ------------------------------
  axi_mem_reader u_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ar_valid (i_ar_valid),
    .i_ar       (i_ar),
    .o_ar_ready (o_ar_ready),
    .o_r_valid  (o_r_valid),
    .o_r        (o_r),
    .i_r_ready  (i_r_ready),
    .o_rd_en    (rd_en),
    .o_rd_addr  (rd_addr),
    .i_rd_data  (rd_data)
  );

  axi_mem_array u_array (
    .clk       (clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_wr_strb (wr_strb),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

endmodule

//--- design/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,

  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready
);

  logic     main_valid;
  logic     skid_valid;
  payload_t main_data;
  payload_t skid_data;
  logic     in_fire;

  // Not full as long as the skid slot is free
  assign o_ready = !skid_valid;
  assign in_fire = i_valid && o_ready;

  // Empty buffer passes the input straight through
  assign o_valid = main_valid || i_valid;
  assign o_data  = main_valid ? main_data : i_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (skid_valid) begin
      // Full, main drains and skid moves up
      if (i_ready) begin
        skid_valid <= 1'b0;
      end
    end else if (main_valid) begin
      if (i_ready) begin
        main_valid <= in_fire;
      end else begin
        skid_valid <= in_fire;
      end
    end else begin
      main_valid <= in_fire && !i_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (skid_valid) begin
      if (i_ready) begin
        main_data <= skid_data;
      end
    end else if (main_valid && !i_ready) begin
      skid_data <= i_data;
    end else begin
      main_data <= i_data;
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AXI memory testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module axi_mem_tb \
  -f axi_mem_top.f \
  -o axi_mem_sim

./obj_dir/axi_mem_sim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation passed"
